//--- list.f
+incdir+verilog
verilog/spram_pkg.sv
verilog/sp_macro_model.sv
verilog/spram_req_stage.sv
verilog/spram_macro_array.sv
verilog/spram_rsp_stage.sv
verilog/spram_top.sv
test/spram_checker.sv
test/tb_spram_top.sv

//--- run_sim.sh
#!/bin/sh
set -e

# run from the project root so that list.f paths resolve
cd "$(dirname "$0")"

verilator --binary --timing -f list.f --top-module tb_spram_top -Mdir obj_dir -o sim_spram

./obj_dir/sim_spram > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
    echo "run_sim.sh: failure reported in sim.log"
    exit 1
fi

echo "run_sim.sh: no failure in sim.log"
exit 0

//--- test/spram_checker.sv
`timescale 1ns/100ps
`include "spram_cfg.svh"

module spram_checker (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ce,
    input  logic                   we,
    input  spram_pkg::spram_strb_t wstrb,
    input  logic [`SPRAM_AW-1:0]   addr,
    input  logic [`SPRAM_DW-1:0]   wdata,
    input  logic                   rvalid,
    input  logic [`SPRAM_DW-1:0]   rdata,
    output int                     error_count,
    output int                     read_count,   // responses compared
    output int                     pending       // reads still waiting for rvalid
);

    import spram_pkg::*;

    localparam int READ_LATENCY = 3;  // edges from request to rvalid sample

    logic [`SPRAM_DW-1:0] model_mem [2**`SPRAM_AW];
    logic [`SPRAM_DW-1:0] exp_data [$];
    logic [`SPRAM_AW-1:0] exp_addr [$];
    int                   exp_edge [$];  // edge on which the read was sampled
    logic [`SPRAM_DW-1:0] held_rdata;
    int                   edge_count;

    initial begin
        error_count = 0;
        read_count  = 0;
        pending     = 0;
        edge_count  = 0;
        held_rdata  = '0;
    end

    // byte strobe rule of the host bus
    function automatic logic [`SPRAM_DW-1:0] merge_bytes(
        input logic [`SPRAM_DW-1:0] old_word,
        input logic [`SPRAM_DW-1:0] new_word,
        input spram_strb_t          strb
    );
        logic [`SPRAM_DW-1:0] result;
        result = old_word;
        for (int i = 0; i < $bits(spram_strb_t); i++) begin
            if (strb[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    task automatic check_response();
        logic [`SPRAM_DW-1:0] want;
        logic [`SPRAM_AW-1:0] want_addr;
        int                   issued;
        // reads whose response slot has already passed
        while (exp_edge.size() != 0 && exp_edge[0] + READ_LATENCY < edge_count) begin
            $display("error: read of address %h got no rvalid within %0d edges",
                     exp_addr[0], READ_LATENCY);
            error_count++;
            void'(exp_data.pop_front());
            void'(exp_addr.pop_front());
            void'(exp_edge.pop_front());
        end
        if (rvalid) begin
            if (exp_data.size() == 0) begin
                $display("error: rvalid seen at edge %0d with no read outstanding",
                         edge_count);
                error_count++;
            end else begin
                want      = exp_data.pop_front();
                want_addr = exp_addr.pop_front();
                issued    = exp_edge.pop_front();
                read_count++;
                if (rdata !== want) begin
                    $display("Mismatch rdata: addr 0x%h expected 0x%h got 0x%h",
                             want_addr, want, rdata);
                    error_count++;
                end
                if (issued + READ_LATENCY != edge_count) begin
                    $display("error: response for address %h came on edge %0d, not %0d",
                             want_addr, edge_count, issued + READ_LATENCY);
                    error_count++;
                end
            end
            held_rdata = rdata;
        end else if (rdata !== held_rdata) begin
            $display("Mismatch rdata: held value 0x%h changed to 0x%h without rvalid",
                     held_rdata, rdata);
            error_count++;
            held_rdata = rdata;  // follow the new value
        end
    endtask

    // outputs are sampled before the edge updates them
    always @(posedge clk) begin
        edge_count++;
        if (reset) begin
            exp_data.delete();  // reads in flight are lost
            exp_addr.delete();
            exp_edge.delete();
            held_rdata = '0;
        end else begin
            check_response();
            if (ce && we) begin
                model_mem[addr] = merge_bytes(model_mem[addr], wdata, wstrb);
            end else if (ce) begin
                exp_data.push_back(model_mem[addr]);
                exp_addr.push_back(addr);
                exp_edge.push_back(edge_count);
            end
        end
        pending = exp_data.size();
    end

endmodule

//--- test/tb_spram_top.sv
`timescale 1ns/100ps
`include "spram_cfg.svh"

module tb_spram_top;

    import spram_pkg::*;

    localparam int WORDS       = 2 ** `SPRAM_AW;
    localparam int BANK_BITS   = `SPRAM_AW - `SPRAM_MACRO_AW;
    localparam int DRAIN_LIMIT = 20;  // edges allowed for the last reads

    typedef logic [`SPRAM_AW-1:0] addr_t;
    typedef logic [`SPRAM_DW-1:0] word_t;

    logic        clk = 1'b0;
    logic        reset;
    logic        ce;
    logic        we;
    spram_strb_t wstrb;
    addr_t       addr;
    word_t       wdata;
    logic        rvalid;
    word_t       rdata;
    int          error_count;
    int          read_count;
    int          pending;
    int          timeout_count;

    always #4 clk = ~clk;

    spram_top i_spram_top (
        .clk    (clk),
        .reset  (reset),
        .ce     (ce),
        .we     (we),
        .wstrb  (wstrb),
        .addr   (addr),
        .wdata  (wdata),
        .rvalid (rvalid),
        .rdata  (rdata)
    );

    spram_checker i_checker (
        .clk         (clk),
        .reset       (reset),
        .ce          (ce),
        .we          (we),
        .wstrb       (wstrb),
        .addr        (addr),
        .wdata       (wdata),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .error_count (error_count),
        .read_count  (read_count),
        .pending     (pending)
    );

    function automatic word_t random_word();
        return {$urandom(), $urandom()};
    endfunction

    function automatic addr_t random_addr();
        return addr_t'($urandom());
    endfunction

    function automatic spram_strb_t random_strobe();
        return spram_strb_t'($urandom());
    endfunction

    task automatic issue_write(input addr_t a, input word_t d, input spram_strb_t s);
        @(posedge clk);
        ce    <= 1'b1;
        we    <= 1'b1;
        addr  <= a;
        wdata <= d;
        wstrb <= s;
    endtask

    task automatic issue_read(input addr_t a);
        @(posedge clk);
        ce    <= 1'b1;
        we    <= 1'b0;
        addr  <= a;
        wstrb <= '0;
        wdata <= random_word();  // ignored on reads
    endtask

    task automatic go_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            ce <= 1'b0;
            we <= 1'b0;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset <= 1'b1;
        ce    <= 1'b0;
        we    <= 1'b0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
    endtask

    // idles until every read is answered, pending is read away from the edge
    task automatic wait_drain(input string phase);
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            ce <= 1'b0;
            we <= 1'b0;
            @(negedge clk);
            waited++;
        end while (pending != 0 && waited < DRAIN_LIMIT);
        if (pending != 0) begin
            $display("timeout: %0d reads of the %s phase never got rvalid", pending, phase);
            timeout_count++;
        end
    endtask

    task automatic masked_writes(input int count);
        addr_t picked [$];
        addr_t a;
        for (int n = 0; n < count; n++) begin
            a = random_addr();
            picked.push_back(a);
            issue_write(a, random_word(), random_strobe());
        end
        foreach (picked[i]) begin
            issue_read(picked[i]);
        end
    endtask

    // back-to-back reads that change bank on every request
    task automatic bank_hopping_reads(input int count);
        addr_t a;
        for (int n = 0; n < count; n++) begin
            a = random_addr();
            a[`SPRAM_AW-1:`SPRAM_MACRO_AW] = BANK_BITS'(n);
            issue_read(a);
        end
    endtask

    task automatic random_mix(input int cycles);
        int kind;
        for (int n = 0; n < cycles; n++) begin
            kind = int'($urandom() % 10);
            if (kind < 5) begin
                issue_read(random_addr());
            end else if (kind < 8) begin
                issue_write(random_addr(), random_word(), random_strobe());
            end else begin
                go_idle(1);
            end
        end
    endtask

    task automatic run_phases();
        for (int a = 0; a < WORDS; a++) begin
            issue_write(addr_t'(a), random_word(), '1);
        end
        for (int a = 0; a < WORDS; a++) begin
            issue_read(addr_t'(a));
        end
        wait_drain("fill and read back");
        if (timeout_count != 0) return;
        masked_writes(128);
        wait_drain("masked write");
        if (timeout_count != 0) return;
        bank_hopping_reads(64);
        random_mix(2000);
        wait_drain("random mix");
        if (timeout_count != 0) return;
        go_idle(12);  // rdata must hold through idle and writes
        for (int n = 0; n < 16; n++) begin
            issue_write(random_addr(), random_word(), random_strobe());
        end
        go_idle(6);
        for (int n = 0; n < 3; n++) begin
            issue_read(random_addr());
        end
        apply_reset();  // lands on reads still in flight
        bank_hopping_reads(32);
        random_mix(500);
        wait_drain("after reset");
    endtask

    initial begin
        void'($urandom(32'h8187_1f3d));
        timeout_count = 0;
        reset = 1'b1;
        ce    = 1'b0;
        we    = 1'b0;
        wstrb = '0;
        addr  = '0;
        wdata = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        run_phases();
        $display("reads checked: %0d, errors: %0d, timeouts: %0d",
                 read_count, error_count, timeout_count);
        if (timeout_count == 0 && error_count == 0 && read_count > 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

//--- verilog/sp_macro_model.sv
`timescale 1ns/100ps

module sp_macro_model #(
    parameter int AW = 8,   // depth bits
    parameter int DW = 32   // word width
) (
    input  logic          clk,
    input  logic          ce_in,      // chip enable
    input  logic          we_in,      // write enable
    input  logic [DW-1:0] w_mask_in,  // per bit write mask
    input  logic [AW-1:0] addr_in,
    input  logic [DW-1:0] wd_in,
    output logic [DW-1:0] rd_out      // registered read data
);

    logic [DW-1:0] mem [2**AW];

    // masked write, untouched bits keep their old value
    always_ff @(posedge clk) begin
        if (ce_in && we_in) begin
            mem[addr_in] <= (mem[addr_in] & ~w_mask_in) | (wd_in & w_mask_in);
        end
    end

    // rd_out holds across writes and idle cycles
    always_ff @(posedge clk) begin
        if (ce_in && !we_in) begin
            rd_out <= mem[addr_in];
        end
    end

endmodule

//--- verilog/spram_cfg.svh
`ifndef SPRAM_CFG_SVH
`define SPRAM_CFG_SVH

// host word width in bits
`define SPRAM_DW 64

// host word address width
`define SPRAM_AW 10

// address bits of one macro, 256 words
`define SPRAM_MACRO_AW 8

// data width of one macro
`define SPRAM_MACRO_DW 32

// 4 banks x 2 lanes with the values above

`endif

//--- verilog/spram_macro_array.sv
`timescale 1ns/100ps
`include "spram_cfg.svh"

module spram_macro_array (
    input  logic                  clk,
    input  logic                  reset,
    input  spram_pkg::spram_req_t req,
    output logic [`SPRAM_DW-1:0]  dout   // merged read data
);

    localparam int BANK_BITS = `SPRAM_AW - `SPRAM_MACRO_AW;
    localparam int BANKS     = 2 ** BANK_BITS;
    localparam int MDW       = `SPRAM_MACRO_DW;
    localparam int LANES     = `SPRAM_DW / MDW;

    logic [BANK_BITS-1:0]            req_bank;  // bank of the current request
    logic [BANK_BITS-1:0]            rd_bank;   // bank of the read in flight
    logic [`SPRAM_MACRO_AW-1:0]      mem_addr;  // word within a macro
    logic [BANKS-1:0][`SPRAM_DW-1:0] bank_dout;

    assign req_bank = req.addr[`SPRAM_AW-1:`SPRAM_MACRO_AW];
    assign mem_addr = req.addr[`SPRAM_MACRO_AW-1:0];

    // loaded on the same edge that the macros register their read data,
    // so it steers the merge while that data is on rd_out
    always_ff @(posedge clk) begin
        if (reset) begin
            rd_bank <= '0;
        end else if (req.ce && !req.we) begin
            rd_bank <= req_bank;
        end
    end

    for (genvar b = 0; b < BANKS; b++) begin : g_bank
        logic bank_ce;
        logic bank_we;

        assign bank_ce = req.ce && (req_bank == BANK_BITS'(b));  // bank hit
        assign bank_we = req.we && bank_ce;

        // each lane holds one macro-wide slice of the host word
        for (genvar l = 0; l < LANES; l++) begin : g_lane
            sp_macro_model #(
                .AW(`SPRAM_MACRO_AW),
                .DW(MDW)
            ) i_macro (
                .clk       (clk),
                .ce_in     (bank_ce),
                .we_in     (bank_we),
                .w_mask_in (req.wmask[l*MDW +: MDW]),
                .addr_in   (mem_addr),
                .wd_in     (req.din[l*MDW +: MDW]),
                .rd_out    (bank_dout[b][l*MDW +: MDW])
            );
        end
    end

    // OR merge, only the bank that was read is let through
    always_comb begin
        dout = '0;
        for (int b = 0; b < BANKS; b++) begin
            dout = dout | (bank_dout[b] & {`SPRAM_DW{rd_bank == BANK_BITS'(b)}});
        end
    end

endmodule

//--- verilog/spram_pkg.sv
`include "spram_cfg.svh"

package spram_pkg;

    // one strobe per byte of the host word
    typedef logic [`SPRAM_DW/8-1:0] spram_strb_t;

    // request as seen by the macro array
    typedef struct packed {
        logic                 ce;     // chip enable
        logic                 we;     // write enable
        logic [`SPRAM_DW-1:0] wmask;  // per bit write mask
        logic [`SPRAM_AW-1:0] addr;   // word address
        logic [`SPRAM_DW-1:0] din;    // write data
    } spram_req_t;

    // read response to the host
    typedef struct packed {
        logic                 rvalid; // one cycle per read
        logic [`SPRAM_DW-1:0] rdata;  // held until next read
    } spram_rsp_t;

endpackage

//--- verilog/spram_req_stage.sv
`timescale 1ns/100ps
`include "spram_cfg.svh"

module spram_req_stage (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ce,
    input  logic                   we,
    input  spram_pkg::spram_strb_t wstrb,
    input  logic [`SPRAM_AW-1:0]   addr,
    input  logic [`SPRAM_DW-1:0]   wdata,
    output spram_pkg::spram_req_t  req,
    output logic                   rd_issue  // req holds a read
);

    import spram_pkg::*;

    spram_req_t req_d;
    logic       wr_req;

    assign wr_req = ce && we;

    always_comb begin
        req_d.ce   = ce;
        req_d.we   = we;
        req_d.addr = addr;
        req_d.din  = wdata;
        // each strobe covers eight mask bits, reads never write
        for (int i = 0; i < $bits(spram_strb_t); i++) begin
            req_d.wmask[8*i +: 8] = {8{wr_req && wstrb[i]}};
        end
    end

    always_ff @(posedge clk) begin
        req      <= req_d;
        rd_issue <= ce && !we;
        if (reset) begin
            req.ce   <= 1'b0;  // payload fields left as they are
            rd_issue <= 1'b0;
        end
    end

endmodule

//--- verilog/spram_rsp_stage.sv
`timescale 1ns/100ps
`include "spram_cfg.svh"

module spram_rsp_stage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rd_issue,  // read presented to the macros
    input  logic [`SPRAM_DW-1:0]  dout,      // macro read data
    output spram_pkg::spram_rsp_t rsp
);

    logic rd_issue_q;  // macro data valid this cycle

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_issue_q <= 1'b0;
            rsp        <= '0;
        end else begin
            rd_issue_q <= rd_issue;
            rsp.rvalid <= rd_issue_q;  // single cycle pulse
            if (rd_issue_q) begin
                rsp.rdata <= dout;     // held until the next read
            end
        end
    end

endmodule

//--- verilog/spram_top.sv
`timescale 1ns/100ps
`include "spram_cfg.svh"

module spram_top (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ce,      // request strobe
    input  logic                   we,      // write when set, else read
    input  spram_pkg::spram_strb_t wstrb,   // byte strobes
    input  logic [`SPRAM_AW-1:0]   addr,
    input  logic [`SPRAM_DW-1:0]   wdata,
    output logic                   rvalid,
    output logic [`SPRAM_DW-1:0]   rdata
);

    import spram_pkg::*;

    spram_req_t           req;
    spram_rsp_t           rsp;
    logic                 rd_issue;
    logic [`SPRAM_DW-1:0] dout;

    spram_req_stage i_req_stage (
        .clk      (clk),
        .reset    (reset),
        .ce       (ce),
        .we       (we),
        .wstrb    (wstrb),
        .addr     (addr),
        .wdata    (wdata),
        .req      (req),
        .rd_issue (rd_issue)
    );

    spram_macro_array i_macro_array (
        .clk   (clk),
        .reset (reset),
        .req   (req),
        .dout  (dout)
    );

    spram_rsp_stage i_rsp_stage (
        .clk      (clk),
        .reset    (reset),
        .rd_issue (rd_issue),
        .dout     (dout),
        .rsp      (rsp)
    );

    assign rvalid = rsp.rvalid;
    assign rdata  = rsp.rdata;

endmodule
